//--- rtl/axi_delay_pkg.sv
/*
 * Shared definitions for the AXI delay injector
 *   Bus widths and the hold counter width
 *   Random stall bound and fixed hold time per channel
 *   Burst type and holding stage state enums
 *   Packed payload structs for the AW, W, B, AR and R channels
 */

package axi_delay_pkg;

  // Bus widths
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned id_width   = 4;
  localparam int unsigned len_width  = 8;
  // One strobe bit per data byte
  localparam int unsigned strb_width = data_width / 8;
  localparam int unsigned resp_width = 2;

  // Width of the pseudo-random source behind the random stalls
  localparam int unsigned lfsr_width = 16;

  // Longest random hold, in cycles
  localparam int unsigned max_stall = 7;

  // Fixed hold per channel, in cycles
  // A zero here switches that channel to a random hold of 1 to max_stall
  localparam int unsigned aw_fixed_delay = 0;
  localparam int unsigned w_fixed_delay  = 2;
  localparam int unsigned ar_fixed_delay = 0;
  localparam int unsigned b_fixed_delay  = 3;
  localparam int unsigned r_fixed_delay  = 1;

  // The hold counter must fit max_stall and every fixed hold above
  localparam int unsigned cnt_width = $clog2(max_stall + 1);

  typedef enum logic [1:0] {
    fixed = 2'b00,
    incr  = 2'b01,
    wrap  = 2'b10
  } axi_burst_e;

  // A holding stage is either free, counting down, or offering its beat
  typedef enum logic [1:0] {
    empty   = 2'b00,
    hold    = 2'b01,
    present = 2'b10
  } delay_state_e;

  // Write address beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
    axi_burst_e            burst;
  } axi_aw_t;

  // Write data beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
  } axi_w_t;

  // Write response beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [resp_width-1:0] resp;
  } axi_b_t;

  // Read address beats carry the same fields as write address beats
  typedef axi_aw_t axi_ar_t;

  // Read data beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [resp_width-1:0] resp;
    logic                  last;
  } axi_r_t;

endpackage

//--- rtl/stall_lfsr.sv
/*
 * Galois LFSR feeding the random hold counts of a delay stage
 *   Resets to its seed and advances only when stepped
 */

`timescale 1ns/100ps

module stall_lfsr #(
  // Must be nonzero, otherwise the register locks up at zero
  parameter logic [axi_delay_pkg::lfsr_width-1:0] seed = 16'hace1
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  step,
  output logic [axi_delay_pkg::lfsr_width-1:0] value
);

  logic [axi_delay_pkg::lfsr_width-1:0] state_q;
  logic [axi_delay_pkg::lfsr_width-1:0] state_next;

  // Shift right and fold the outgoing bit back into the tap positions
  // Taps for x^16 + x^14 + x^13 + x^11 + 1, a maximal length polynomial
  always_comb begin
    state_next = state_q >> 1;
    if (state_q[0]) begin
      state_next = state_next ^ 16'hb400;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= seed;
    end else if (step) begin
      state_q <= state_next;
    end
  end

  assign value = state_q;

endmodule

//--- rtl/stream_delay.sv
/*
 * Single-beat holding stage for one valid/ready channel
 *   Captures a beat, holds it for a fixed or pseudo-random number of cycles,
 *   then offers it downstream until it is taken
 *   Random mode is selected by a fixed delay of zero and adds an LFSR
 */

`timescale 1ns/100ps

module stream_delay #(
  parameter type                                 beat_t      = logic,
  parameter int unsigned                         fixed_delay = 0,
  parameter logic [axi_delay_pkg::lfsr_width-1:0] lfsr_seed  = 16'h0001
) (
  input  logic  clk,
  input  logic  arst_n,
  // Upstream side
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,
  // Downstream side
  output logic  out_valid,
  input  logic  out_ready,
  output beat_t out_beat
);

  axi_delay_pkg::delay_state_e state;
  logic [axi_delay_pkg::cnt_width-1:0] hold_cnt;
  logic [axi_delay_pkg::cnt_width-1:0] hold_load;
  logic capture;
  beat_t beat_q;

  // A beat is taken only while the stage is free
  assign in_ready = (state == axi_delay_pkg::empty);
  assign capture  = in_valid && in_ready;

  // Hold length loaded on capture
  if (fixed_delay == 0) begin : g_random
    logic [axi_delay_pkg::lfsr_width-1:0] lfsr_value;
    logic [axi_delay_pkg::lfsr_width-1:0] stall_mod;

    // Stepped on every capture so back-to-back beats see different holds
    stall_lfsr #(
      .seed (lfsr_seed)
    ) stall_lfsr_i (
      .clk    (clk),
      .arst_n (arst_n),
      .step   (capture),
      .value  (lfsr_value)
    );

    // Range 0 to max_stall-1, shifted up by one so a hold is never empty
    assign stall_mod = lfsr_value % 16'(axi_delay_pkg::max_stall);
    assign hold_load = stall_mod[axi_delay_pkg::cnt_width-1:0] + 1'b1;
  end else begin : g_fixed
    assign hold_load = fixed_delay[axi_delay_pkg::cnt_width-1:0];
  end

  // Stage FSM
  // The capture edge loads the counter, each hold cycle takes one off,
  // and the edge after it reaches zero makes the beat visible,
  // so out_valid follows the capture by hold_load plus 1 cycles
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= axi_delay_pkg::empty;
      hold_cnt <= '0;
    end else begin
      unique case (state)
        axi_delay_pkg::empty: begin
          if (in_valid) begin
            state    <= axi_delay_pkg::hold;
            hold_cnt <= hold_load;
          end
        end
        axi_delay_pkg::hold: begin
          if (hold_cnt == '0) begin
            state <= axi_delay_pkg::present;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        axi_delay_pkg::present: begin
          // Stay here under back-pressure, the beat is never dropped
          if (out_ready) begin
            state <= axi_delay_pkg::empty;
          end
        end
        default: begin
          state <= axi_delay_pkg::empty;
        end
      endcase
    end
  end

  // Payload is loaded only on capture and stays frozen until the next one
  always_ff @(posedge clk) begin
    if (capture) begin
      beat_q <= in_beat;
    end
  end

  assign out_valid = (state == axi_delay_pkg::present);
  assign out_beat  = beat_q;

endmodule

//--- rtl/axi_delayer.sv
/*
 * AXI delay and stall injector between a manager and a subordinate
 *   One holding stage per channel, all five running independently
 *   AW and AR use random holds, W, B and R use fixed holds
 */

`timescale 1ns/100ps

module axi_delayer (
  input  logic                   clk,
  input  logic                   arst_n,
  // Manager side, requests in
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  axi_delay_pkg::axi_aw_t aw,
  input  logic                   w_valid,
  output logic                   w_ready,
  input  axi_delay_pkg::axi_w_t  w,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  input  axi_delay_pkg::axi_ar_t ar,
  // Manager side, responses out
  output logic                   b_valid,
  input  logic                   b_ready,
  output axi_delay_pkg::axi_b_t  b,
  output logic                   r_valid,
  input  logic                   r_ready,
  output axi_delay_pkg::axi_r_t  r,
  // Subordinate side, requests out
  output logic                   sub_aw_valid,
  input  logic                   sub_aw_ready,
  output axi_delay_pkg::axi_aw_t sub_aw,
  output logic                   sub_w_valid,
  input  logic                   sub_w_ready,
  output axi_delay_pkg::axi_w_t  sub_w,
  output logic                   sub_ar_valid,
  input  logic                   sub_ar_ready,
  output axi_delay_pkg::axi_ar_t sub_ar,
  // Subordinate side, responses in
  input  logic                   sub_b_valid,
  output logic                   sub_b_ready,
  input  axi_delay_pkg::axi_b_t  sub_b,
  input  logic                   sub_r_valid,
  output logic                   sub_r_ready,
  input  axi_delay_pkg::axi_r_t  sub_r
);

  // Write address toward the subordinate, random hold
  stream_delay #(
    .beat_t      (axi_delay_pkg::axi_aw_t),
    .fixed_delay (axi_delay_pkg::aw_fixed_delay),
    .lfsr_seed   (16'hace1)
  ) aw_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (aw_valid),
    .in_ready  (aw_ready),
    .in_beat   (aw),
    .out_valid (sub_aw_valid),
    .out_ready (sub_aw_ready),
    .out_beat  (sub_aw)
  );

  // Write data toward the subordinate
  stream_delay #(
    .beat_t      (axi_delay_pkg::axi_w_t),
    .fixed_delay (axi_delay_pkg::w_fixed_delay)
  ) w_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (w_valid),
    .in_ready  (w_ready),
    .in_beat   (w),
    .out_valid (sub_w_valid),
    .out_ready (sub_w_ready),
    .out_beat  (sub_w)
  );

  // Read address toward the subordinate, seeded apart from AW
  stream_delay #(
    .beat_t      (axi_delay_pkg::axi_ar_t),
    .fixed_delay (axi_delay_pkg::ar_fixed_delay),
    .lfsr_seed   (16'h5eed)
  ) ar_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (ar_valid),
    .in_ready  (ar_ready),
    .in_beat   (ar),
    .out_valid (sub_ar_valid),
    .out_ready (sub_ar_ready),
    .out_beat  (sub_ar)
  );

  // Write response back to the manager
  stream_delay #(
    .beat_t      (axi_delay_pkg::axi_b_t),
    .fixed_delay (axi_delay_pkg::b_fixed_delay)
  ) b_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (sub_b_valid),
    .in_ready  (sub_b_ready),
    .in_beat   (sub_b),
    .out_valid (b_valid),
    .out_ready (b_ready),
    .out_beat  (b)
  );

  // Read data back to the manager
  stream_delay #(
    .beat_t      (axi_delay_pkg::axi_r_t),
    .fixed_delay (axi_delay_pkg::r_fixed_delay)
  ) r_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (sub_r_valid),
    .in_ready  (sub_r_ready),
    .in_beat   (sub_r),
    .out_valid (r_valid),
    .out_ready (r_ready),
    .out_beat  (r)
  );

endmodule

//--- bench/axi_sub_model.sv
/*
 * Subordinate model for the delay injector testbench
 *   Accepts AW, W and AR beats with a random ready pattern
 *   Answers each write with B okay and each read with R carrying the inverted address
 */

`timescale 1ns/100ps

module axi_sub_model #(
  parameter logic [31:0] seed = 32'd98346
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   sub_aw_valid,
  output logic                   sub_aw_ready,
  input  axi_delay_pkg::axi_aw_t sub_aw,
  input  logic                   sub_w_valid,
  output logic                   sub_w_ready,
  input  axi_delay_pkg::axi_w_t  sub_w,
  input  logic                   sub_ar_valid,
  output logic                   sub_ar_ready,
  input  axi_delay_pkg::axi_ar_t sub_ar,
  output logic                   sub_b_valid,
  input  logic                   sub_b_ready,
  output axi_delay_pkg::axi_b_t  sub_b,
  output logic                   sub_r_valid,
  input  logic                   sub_r_ready,
  output axi_delay_pkg::axi_r_t  sub_r
);

  logic [31:0] rnd;
  // Write IDs waiting for their B, read requests stored as id and address
  logic [3:0]  wr_ids [$];
  logic [35:0] rd_reqs [$];
  int unsigned w_beats;
  bit          b_taken;
  bit          r_taken;
  logic [35:0] req;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    // Offset from the manager's stream so the two patterns are unrelated
    rnd = seed ^ 32'h2545_f491;
    {sub_aw_ready, sub_w_ready, sub_ar_ready, sub_b_valid, sub_r_valid} = '0;
    sub_b = '0;
    sub_r = '0;
    w_beats = 0;
    b_taken = 0;
    r_taken = 0;
  end

  // Transfers are seen on the rising edge and acted on at the next falling edge
  always @(posedge clk) begin
    if (arst_n) begin
      if (sub_aw_valid && sub_aw_ready) wr_ids.push_back(sub_aw.id);
      if (sub_w_valid && sub_w_ready) w_beats++;
      if (sub_ar_valid && sub_ar_ready) rd_reqs.push_back({sub_ar.id, sub_ar.addr});
      if (sub_b_valid && sub_b_ready) b_taken = 1'b1;
      if (sub_r_valid && sub_r_ready) r_taken = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (arst_n) begin
      rnd = xorshift(rnd);
      sub_aw_ready = rnd[0];
      sub_w_ready  = rnd[1];
      sub_ar_ready = rnd[2];
      if (b_taken) begin
        sub_b_valid = 1'b0;
        b_taken = 1'b0;
      end
      // A B needs both its address and its data beat, in either order
      if (!sub_b_valid && wr_ids.size() > 0 && w_beats > 0 && rnd[3]) begin
        sub_b.id   = wr_ids.pop_front();
        sub_b.resp = 2'b00;
        w_beats--;
        sub_b_valid = 1'b1;
      end
      if (r_taken) begin
        sub_r_valid = 1'b0;
        r_taken = 1'b0;
      end
      if (!sub_r_valid && rd_reqs.size() > 0 && rnd[4]) begin
        req = rd_reqs.pop_front();
        sub_r.id   = req[35:32];
        sub_r.data = ~req[31:0];
        sub_r.resp = 2'b00;
        sub_r.last = 1'b1;
        sub_r_valid = 1'b1;
      end
    end
  end

endmodule

//--- bench/tb_axi_delayer.sv
/*
 * Testbench for the AXI delay injector
 *   Clock, reset, manager stimulus and a subordinate model
 *   Per channel scoreboards, latency and back-pressure assertions
 *   End to end checks of B and R against outstanding requests
 */

`timescale 1ns/100ps

module tb_axi_delayer;

  localparam int unsigned n_trans = 40;
  localparam int unsigned timeout = 200;

  logic clk;
  logic arst_n;
  logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
  logic b_valid, b_ready, r_valid, r_ready;
  axi_delay_pkg::axi_aw_t aw, sub_aw;
  axi_delay_pkg::axi_w_t  w, sub_w;
  axi_delay_pkg::axi_ar_t ar, sub_ar;
  axi_delay_pkg::axi_b_t  b, sub_b;
  axi_delay_pkg::axi_r_t  r, sub_r;
  logic sub_aw_valid, sub_aw_ready, sub_w_valid, sub_w_ready, sub_ar_valid, sub_ar_ready;
  logic sub_b_valid, sub_b_ready, sub_r_valid, sub_r_ready;

  logic [31:0] rnd;
  int unsigned errors, checks, cycle, b_seen, r_seen, waited;
  // Channel index 0 to 4 stands for AW, W, AR, B and R
  string       names [5] = '{"aw", "w", "ar", "b", "r"};
  logic [63:0] beat_q [5][$];
  logic [63:0] held [5];
  int unsigned cap_cycle [5];
  logic        prev_valid [5];
  logic        stalled [5];
  logic [15:0] lat_seen [5];
  logic [3:0]  wr_open [$];
  logic [35:0] rd_open [$];

  axi_delayer axi_delayer_i (.*);

  axi_sub_model #(
    .seed (32'd98346)
  ) axi_sub_model_i (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void value_mismatch(input string test, input logic [63:0] exp,
                                         input logic [63:0] act);
    errors++;
    $display("CHECK FAILED %s: expected %0h actual %0h", test, exp, act);
  endfunction

  function automatic void report_failure(input string what);
    errors++;
    $display("ERROR: %s", what);
  endfunction

  task automatic abort_run(input string what);
    errors++;
    $display("ERROR: timeout while waiting for %s", what);
    $display("errors: %0d checks: %0d", errors, checks);
    $display("TB FAILED");
    $finish;
  endtask

  function automatic int unsigned fixed_hold(input int ch);
    case (ch)
      0: return axi_delay_pkg::aw_fixed_delay;
      1: return axi_delay_pkg::w_fixed_delay;
      2: return axi_delay_pkg::ar_fixed_delay;
      3: return axi_delay_pkg::b_fixed_delay;
      default: return axi_delay_pkg::r_fixed_delay;
    endcase
  endfunction

  // Near side is where a stage captures, far side is where it presents
  function automatic void track_channel(input int ch, input logic near_fire,
      input logic near_ready, input logic [63:0] near_beat, input logic far_valid,
      input logic far_ready, input logic [63:0] far_beat);
    int unsigned lat;
    logic [63:0] exp;
    // A stalled beat keeps valid and payload, and the stage stays closed
    if (stalled[ch]) begin
      checks++;
      assert (far_valid && !near_ready)
        else report_failure({names[ch], " dropped valid or reopened under back-pressure"});
      assert (far_beat == held[ch]) else value_mismatch({names[ch], " stall payload"},
                                                        held[ch], far_beat);
    end
    // Valid rose after the previous edge, so count edges from the capture to that one
    if (far_valid && !prev_valid[ch]) begin
      lat = cycle - 1 - cap_cycle[ch];
      checks++;
      if (fixed_hold(ch) != 0) begin
        assert (lat == fixed_hold(ch) + 1)
          else value_mismatch({names[ch], " fixed latency"}, fixed_hold(ch) + 1, lat);
      end else begin
        assert (lat >= 2 && lat <= axi_delay_pkg::max_stall + 1)
          else value_mismatch({names[ch], " random latency upper bound"},
                              axi_delay_pkg::max_stall + 1, lat);
        lat_seen[ch][lat[3:0]] = 1'b1;
      end
    end
    if (far_valid && far_ready) begin
      checks++;
      if (beat_q[ch].size() == 0) begin
        report_failure({names[ch], " beat left the injector with none pending"});
      end else begin
        exp = beat_q[ch].pop_front();
        assert (far_beat == exp) else value_mismatch({names[ch], " order"}, exp, far_beat);
      end
    end
    if (near_fire) begin
      beat_q[ch].push_back(near_beat);
      cap_cycle[ch] = cycle;
    end
    stalled[ch]    = far_valid && !far_ready;
    held[ch]       = far_beat;
    prev_valid[ch] = far_valid;
  endfunction

  function automatic void check_write_response();
    int k;
    bit found;
    found = 0;
    checks++;
    for (k = 0; k < wr_open.size() && !found; k++) begin
      if (wr_open[k] == b.id) begin
        wr_open.delete(k);
        found = 1;
      end
    end
    assert (found) else report_failure($sformatf("B id %0h has no outstanding write", b.id));
    assert (b.resp == 2'b00) else value_mismatch("b resp", 0, b.resp);
    b_seen++;
  endfunction

  function automatic void check_read_response();
    int k;
    bit found;
    logic [31:0] exp_data;
    found = 0;
    exp_data = '0;
    checks++;
    for (k = 0; k < rd_open.size() && !found; k++) begin
      if (rd_open[k][35:32] == r.id) begin
        exp_data = ~rd_open[k][31:0];
        rd_open.delete(k);
        found = 1;
      end
    end
    assert (found) else report_failure($sformatf("R id %0h has no outstanding read", r.id));
    assert (!found || r.data == exp_data) else value_mismatch("r data", exp_data, r.data);
    assert (r.resp == 2'b00 && r.last) else report_failure("R beat without okay and last");
    r_seen++;
  endfunction

  function automatic void check_reset_outputs(input string when);
    checks++;
    assert (!b_valid && !r_valid && !sub_aw_valid && !sub_w_valid && !sub_ar_valid)
      else report_failure({"a valid output is not low ", when});
  endfunction

  // All samples are taken on the rising edge, where driven inputs are settled
  always @(posedge clk) begin
    if (arst_n) begin
      track_channel(0, aw_valid && aw_ready, aw_ready, aw, sub_aw_valid, sub_aw_ready, sub_aw);
      track_channel(1, w_valid && w_ready, w_ready, w, sub_w_valid, sub_w_ready, sub_w);
      track_channel(2, ar_valid && ar_ready, ar_ready, ar, sub_ar_valid, sub_ar_ready, sub_ar);
      track_channel(3, sub_b_valid && sub_b_ready, sub_b_ready, sub_b, b_valid, b_ready, b);
      track_channel(4, sub_r_valid && sub_r_ready, sub_r_ready, sub_r, r_valid, r_ready, r);
      if (aw_valid && aw_ready) wr_open.push_back(aw.id);
      if (ar_valid && ar_ready) rd_open.push_back({ar.id, ar.addr});
      if (b_valid && b_ready) check_write_response();
      if (r_valid && r_ready) check_read_response();
      cycle++;
    end
  end

  // Manager response readies follow a pseudo-random pattern
  always @(negedge clk) begin
    if (arst_n) begin
      rnd = xorshift(rnd);
      b_ready = rnd[0];
      r_ready = rnd[7];
    end
  end

  // Returns on the rising edge where the channel's beat transferred
  task automatic wait_accept(input int ch);
    int unsigned count;
    bit taken;
    count = 0;
    taken = 0;
    while (!taken) begin
      @(posedge clk);
      case (ch)
        0: taken = aw_ready;
        1: taken = w_ready;
        default: taken = ar_ready;
      endcase
      count++;
      if (!taken && count > timeout) abort_run({names[ch], " ready at the manager side"});
    end
  endtask

  task automatic drive_writes();
    int i;
    logic [31:0] addr;
    @(negedge clk);
    for (i = 0; i < n_trans; i++) begin
      addr = 32'h1000_0000 + i * 16;
      aw_valid = 1'b1;
      aw.id    = i[3:0];
      aw.addr  = addr;
      aw.len   = '0;
      aw.burst = axi_delay_pkg::incr;
      wait_accept(0);
      @(negedge clk);
      aw_valid = 1'b0;
      // Write data is tied to its address so misrouted beats stand out
      w_valid = 1'b1;
      w.data  = addr ^ 32'hc3a5_0f96;
      w.strb  = '1;
      w.last  = 1'b1;
      wait_accept(1);
      @(negedge clk);
      w_valid = 1'b0;
    end
  endtask

  task automatic drive_reads();
    int i;
    @(negedge clk);
    for (i = 0; i < n_trans; i++) begin
      ar_valid = 1'b1;
      ar.id    = 4'(i + 5);
      ar.addr  = 32'h2000_0000 + i * 32;
      ar.len   = '0;
      ar.burst = axi_delay_pkg::incr;
      wait_accept(2);
      @(negedge clk);
      ar_valid = 1'b0;
    end
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    {aw_valid, w_valid, ar_valid, b_ready, r_ready} = '0;
    aw = '0;
    w  = '0;
    ar = '0;
    rnd = 32'd98346;
    {errors, checks, cycle, b_seen, r_seen} = '0;
    for (int ch = 0; ch < 5; ch++) begin
      {held[ch], cap_cycle[ch], prev_valid[ch], stalled[ch], lat_seen[ch]} = '0;
    end
    repeat (5) begin
      @(negedge clk);
      check_reset_outputs("while reset is asserted");
    end
    arst_n = 1'b1;
    @(posedge clk);
    check_reset_outputs("at the first edge after reset");
    @(negedge clk);
    checks++;
    assert (aw_ready && w_ready && ar_ready)
      else report_failure("request readies are not high after reset release");

    fork
      drive_writes();
      drive_reads();
    join

    waited = 0;
    while (b_seen < n_trans || r_seen < n_trans) begin
      @(posedge clk);
      waited++;
      if (waited > timeout * 20) abort_run("all B and R responses at the manager");
    end

    checks++;
    for (int ch = 0; ch < 5; ch++) begin
      assert (beat_q[ch].size() == 0) else value_mismatch({names[ch], " pending beats"},
                                                          0, beat_q[ch].size());
    end
    // Random stages must show more than one hold length over the run
    assert ($countones(lat_seen[0]) >= 2) else report_failure("AW hold length never varied");
    assert ($countones(lat_seen[2]) >= 2) else report_failure("AR hold length never varied");

    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/axi_delay_pkg.sv
rtl/stall_lfsr.sv
rtl/stream_delay.sv
rtl/axi_delayer.sv
bench/axi_sub_model.sv
bench/tb_axi_delayer.sv
